// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

  // architectural widths for RV32
  typedef logic [31:0] xlen_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0] reg_idx_t;

  // instruction field widths
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // major opcodes that the core understands
  localparam opcode_t opcode_lui = 7'b01_101_11;
  localparam opcode_t opcode_reg_imm = 7'b00_100_11;
  localparam opcode_t opcode_reg_reg = 7'b01_100_11;

  // add and addi share funct3, add also needs funct7 zero
  localparam funct3_t funct3_add = 3'b000;
  localparam funct7_t funct7_add = 7'b000_0000;

  // register file depth, x0 included
  localparam int num_regs = 32;

  // sequential fetch increment in bytes
  localparam xlen_t pc_step = 32'd4;

endpackage

// ==== rv_pipe_pkg.sv ====
package rv_pipe_pkg;

  // status of whatever sits in writeback this cycle
  // int based so it stays 32 bits wide on the trace port
  typedef enum int {
    // should never show up once reset has drained
    cycle_invalid = 0,
    // bubble left over from reset
    cycle_reset = 1,
    // a real instruction retiring
    cycle_no_stall = 2
  } cycle_status_e;

  // first fetch address out of reset
  localparam rv_isa_pkg::xlen_t reset_pc = 32'd0;

endpackage

// ==== rv_fetch_decode.sv ====
`timescale 1ns/1ns

module rv_fetch_decode (
  input  logic                       clk,
  input  logic                       rst,
  output rv_isa_pkg::xlen_t          pc_to_imem,
  input  rv_isa_pkg::insn_t          insn_from_imem,
  output rv_isa_pkg::xlen_t          d_pc,
  output rv_isa_pkg::insn_t          d_insn,
  output rv_pipe_pkg::cycle_status_e d_status,
  output rv_isa_pkg::reg_idx_t       rs1,
  output rv_isa_pkg::reg_idx_t       rs2
);

  // fetch pc, no branches so it only ever steps forward
  rv_isa_pkg::xlen_t pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= rv_pipe_pkg::reset_pc;
    end else begin
      pc <= pc + rv_isa_pkg::pc_step;
    end
  end

  // imem answers within the same cycle
  assign pc_to_imem = pc;

  // decode stage register
  // during reset it holds a bubble tagged as a reset cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc     <= '0;
      d_insn   <= '0;
      d_status <= rv_pipe_pkg::cycle_reset;
    end else begin
      d_pc     <= pc;
      d_insn   <= insn_from_imem;
      d_status <= rv_pipe_pkg::cycle_no_stall;
    end
  end

  // source register fields for the register file read
  // rs1 sits in bits 19:15, rs2 in bits 24:20 for both R and I formats
  assign rs1 = d_insn[19:15];
  assign rs2 = d_insn[24:20];

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/1ns

module rv_regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  output rv_isa_pkg::xlen_t    rs1_data,
  output rv_isa_pkg::xlen_t    rs2_data,
  input  logic                 w_we,
  input  rv_isa_pkg::reg_idx_t w_rd,
  input  rv_isa_pkg::xlen_t    w_data
);

  // x0 has no storage, only x1 and up are real registers
  rv_isa_pkg::xlen_t regs [1:rv_isa_pkg::num_regs-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < rv_isa_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (w_we && (w_rd != '0)) begin
      regs[w_rd] <= w_data;
    end
  end

  // one read port: x0 reads zero, a same-cycle write is passed through
  function automatic rv_isa_pkg::xlen_t read_port(input rv_isa_pkg::reg_idx_t idx);
    rv_isa_pkg::xlen_t val;
    if (idx == '0) begin
      val = '0;
    end else if (w_we && (w_rd == idx)) begin
      val = w_data;
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

endmodule

// ==== rv_execute.sv ====
`timescale 1ns/1ns

module rv_execute (
  input  logic                       clk,
  input  logic                       rst,
  input  rv_isa_pkg::xlen_t          d_pc,
  input  rv_isa_pkg::insn_t          d_insn,
  input  rv_pipe_pkg::cycle_status_e d_status,
  input  rv_isa_pkg::xlen_t          rs1_data,
  input  rv_isa_pkg::xlen_t          rs2_data,
  input  logic                       fwd_m_we,
  input  rv_isa_pkg::reg_idx_t       fwd_m_rd,
  input  rv_isa_pkg::xlen_t          fwd_m_data,
  input  logic                       fwd_w_we,
  input  rv_isa_pkg::reg_idx_t       fwd_w_rd,
  input  rv_isa_pkg::xlen_t          fwd_w_data,
  output rv_isa_pkg::xlen_t          m_pc,
  output rv_isa_pkg::insn_t          m_insn,
  output rv_pipe_pkg::cycle_status_e m_status,
  output logic                       m_we,
  output rv_isa_pkg::reg_idx_t       m_rd,
  output rv_isa_pkg::xlen_t          m_data
);

  // execute stage register
  rv_isa_pkg::xlen_t          x_pc;
  rv_isa_pkg::insn_t          x_insn;
  rv_pipe_pkg::cycle_status_e x_status;
  rv_isa_pkg::xlen_t          x_rs1_data;
  rv_isa_pkg::xlen_t          x_rs2_data;

  // fields of the instruction in execute
  rv_isa_pkg::opcode_t  opcode;
  rv_isa_pkg::reg_idx_t rd;
  rv_isa_pkg::funct3_t  funct3;
  rv_isa_pkg::reg_idx_t x_rs1;
  rv_isa_pkg::reg_idx_t x_rs2;
  rv_isa_pkg::funct7_t  funct7;

  // operands after the bypass, alu inputs and result
  rv_isa_pkg::xlen_t op_a;
  rv_isa_pkg::xlen_t op_b;
  rv_isa_pkg::xlen_t imm_i;
  rv_isa_pkg::xlen_t imm_u;
  rv_isa_pkg::xlen_t alu_b;
  rv_isa_pkg::xlen_t sum;
  rv_isa_pkg::xlen_t result;
  logic              illegal;

  // control part, a zero insn out of reset decodes as illegal and writes nothing
  always_ff @(posedge clk) begin
    if (rst) begin
      x_pc     <= '0;
      x_insn   <= '0;
      x_status <= rv_pipe_pkg::cycle_reset;
    end else begin
      x_pc     <= d_pc;
      x_insn   <= d_insn;
      x_status <= d_status;
    end
  end

  always_ff @(posedge clk) begin
    x_rs1_data <= rs1_data;
    x_rs2_data <= rs2_data;
  end

  assign {funct7, x_rs2, x_rs1, funct3, rd, opcode} = x_insn;

  // bypass select, memory stage is younger so it wins over writeback
  function automatic rv_isa_pkg::xlen_t bypass(input rv_isa_pkg::reg_idx_t idx,
                                               input rv_isa_pkg::xlen_t rf_val);
    rv_isa_pkg::xlen_t val;
    if (fwd_m_we && (fwd_m_rd == idx) && (idx != '0)) begin
      val = fwd_m_data;
    end else if (fwd_w_we && (fwd_w_rd == idx) && (idx != '0)) begin
      val = fwd_w_data;
    end else begin
      val = rf_val;
    end
    return val;
  endfunction

  always_comb begin
    op_a = bypass(x_rs1, x_rs1_data);
    op_b = bypass(x_rs2, x_rs2_data);
  end

  // I-type immediate sign extended, U-type immediate in the upper bits
  assign imm_i = {{20{x_insn[31]}}, x_insn[31:20]};
  assign imm_u = {x_insn[31:12], 12'b0};

  // one adder shared by addi and add
  assign alu_b = (opcode == rv_isa_pkg::opcode_reg_imm) ? imm_i : op_b;
  assign sum   = op_a + alu_b;

  always_comb begin
    result  = '0;
    illegal = 1'b1;
    case (opcode)
      rv_isa_pkg::opcode_lui: begin
        result  = imm_u;
        illegal = 1'b0;
      end
      rv_isa_pkg::opcode_reg_imm: begin
        // addi only
        if (funct3 == rv_isa_pkg::funct3_add) begin
          result  = sum;
          illegal = 1'b0;
        end
      end
      rv_isa_pkg::opcode_reg_reg: begin
        // add only, sub and the rest fall through as illegal
        if ((funct3 == rv_isa_pkg::funct3_add) && (funct7 == rv_isa_pkg::funct7_add)) begin
          result  = sum;
          illegal = 1'b0;
        end
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  // next memory stage contents
  assign m_pc     = x_pc;
  assign m_insn   = x_insn;
  assign m_status = x_status;
  assign m_rd     = rd;
  assign m_we     = !illegal && (rd != '0);
  assign m_data   = result;

endmodule

// ==== rv_retire.sv ====
`timescale 1ns/1ns

module rv_retire (
  input  logic                       clk,
  input  logic                       rst,
  input  rv_isa_pkg::xlen_t          m_pc,
  input  rv_isa_pkg::insn_t          m_insn,
  input  rv_pipe_pkg::cycle_status_e m_status,
  input  logic                       m_we,
  input  rv_isa_pkg::reg_idx_t       m_rd,
  input  rv_isa_pkg::xlen_t          m_data,
  output logic                       fwd_m_we,
  output rv_isa_pkg::reg_idx_t       fwd_m_rd,
  output rv_isa_pkg::xlen_t          fwd_m_data,
  output logic                       w_we,
  output rv_isa_pkg::reg_idx_t       w_rd,
  output rv_isa_pkg::xlen_t          w_data,
  output rv_isa_pkg::xlen_t          trace_pc,
  output rv_isa_pkg::insn_t          trace_insn,
  output rv_pipe_pkg::cycle_status_e trace_status
);

  // memory stage word that is not needed for the bypass
  rv_isa_pkg::xlen_t          mem_pc;
  rv_isa_pkg::insn_t          mem_insn;
  rv_pipe_pkg::cycle_status_e mem_status;

  // memory stage register
  // no data memory, so this stage only delays the result by a cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_pc     <= '0;
      mem_insn   <= '0;
      mem_status <= rv_pipe_pkg::cycle_reset;
      fwd_m_we   <= 1'b0;
      fwd_m_rd   <= '0;
      fwd_m_data <= '0;
    end else begin
      mem_pc     <= m_pc;
      mem_insn   <= m_insn;
      mem_status <= m_status;
      fwd_m_we   <= m_we;
      fwd_m_rd   <= m_rd;
      fwd_m_data <= m_data;
    end
  end

  // writeback stage register
  // drives the register file write port, the writeback bypass and the trace
  always_ff @(posedge clk) begin
    if (rst) begin
      trace_pc     <= '0;
      trace_insn   <= '0;
      trace_status <= rv_pipe_pkg::cycle_reset;
      w_we         <= 1'b0;
      w_rd         <= '0;
      w_data       <= '0;
    end else begin
      trace_pc     <= mem_pc;
      trace_insn   <= mem_insn;
      trace_status <= mem_status;
      w_we         <= fwd_m_we;
      w_rd         <= fwd_m_rd;
      w_data       <= fwd_m_data;
    end
  end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/1ns

module rv_core (
  input  logic                       clk,
  input  logic                       rst,
  output rv_isa_pkg::xlen_t          pc_to_imem,
  input  rv_isa_pkg::insn_t          insn_from_imem,
  output rv_isa_pkg::xlen_t          trace_pc,
  output rv_isa_pkg::insn_t          trace_insn,
  output rv_pipe_pkg::cycle_status_e trace_status,
  output logic                       trace_we,
  output rv_isa_pkg::reg_idx_t       trace_rd,
  output rv_isa_pkg::xlen_t          trace_data
);

  // decode to execute
  rv_isa_pkg::xlen_t          d_pc;
  rv_isa_pkg::insn_t          d_insn;
  rv_pipe_pkg::cycle_status_e d_status;

  // register file read
  rv_isa_pkg::reg_idx_t rs1;
  rv_isa_pkg::reg_idx_t rs2;
  rv_isa_pkg::xlen_t    rs1_data;
  rv_isa_pkg::xlen_t    rs2_data;

  // execute to memory
  rv_isa_pkg::xlen_t          m_pc;
  rv_isa_pkg::insn_t          m_insn;
  rv_pipe_pkg::cycle_status_e m_status;
  logic                       m_we;
  rv_isa_pkg::reg_idx_t       m_rd;
  rv_isa_pkg::xlen_t          m_data;

  // memory stage bypass back into execute
  logic                 fwd_m_we;
  rv_isa_pkg::reg_idx_t fwd_m_rd;
  rv_isa_pkg::xlen_t    fwd_m_data;

  // writeback, shared by the regfile write, the bypass and the trace
  logic                 w_we;
  rv_isa_pkg::reg_idx_t w_rd;
  rv_isa_pkg::xlen_t    w_data;

  rv_fetch_decode u_fetch_decode (
    .clk            (clk),
    .rst            (rst),
    .pc_to_imem     (pc_to_imem),
    .insn_from_imem (insn_from_imem),
    .d_pc           (d_pc),
    .d_insn         (d_insn),
    .d_status       (d_status),
    .rs1            (rs1),
    .rs2            (rs2)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .w_we     (w_we),
    .w_rd     (w_rd),
    .w_data   (w_data)
  );

  rv_execute u_execute (
    .clk        (clk),
    .rst        (rst),
    .d_pc       (d_pc),
    .d_insn     (d_insn),
    .d_status   (d_status),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .fwd_m_we   (fwd_m_we),
    .fwd_m_rd   (fwd_m_rd),
    .fwd_m_data (fwd_m_data),
    .fwd_w_we   (w_we),
    .fwd_w_rd   (w_rd),
    .fwd_w_data (w_data),
    .m_pc       (m_pc),
    .m_insn     (m_insn),
    .m_status   (m_status),
    .m_we       (m_we),
    .m_rd       (m_rd),
    .m_data     (m_data)
  );

  rv_retire u_retire (
    .clk          (clk),
    .rst          (rst),
    .m_pc         (m_pc),
    .m_insn       (m_insn),
    .m_status     (m_status),
    .m_we         (m_we),
    .m_rd         (m_rd),
    .m_data       (m_data),
    .fwd_m_we     (fwd_m_we),
    .fwd_m_rd     (fwd_m_rd),
    .fwd_m_data   (fwd_m_data),
    .w_we         (w_we),
    .w_rd         (w_rd),
    .w_data       (w_data),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status)
  );

  // the write port is what retires this cycle
  assign trace_we   = w_we;
  assign trace_rd   = w_rd;
  assign trace_data = w_data;

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/1ns

module tb_rv_core;

  // program lengths, also used to size the watchdog
  localparam int len_fill = 8;
  localparam int len_indep = 7;
  localparam int len_chain = 7;
  localparam int len_dist = 11;
  localparam int len_x0 = 11;
  localparam int len_rand = 40;
  localparam int n_tests = 6;
  localparam int watchdog_cycles =
    len_fill + len_indep + len_chain + len_dist + len_x0 + len_rand + 10 * n_tests;
  localparam int imem_depth = 256;

  logic                       clk;
  logic                       rst;
  rv_isa_pkg::xlen_t          pc_to_imem;
  rv_isa_pkg::insn_t          insn_from_imem;
  rv_isa_pkg::xlen_t          trace_pc;
  rv_isa_pkg::insn_t          trace_insn;
  rv_pipe_pkg::cycle_status_e trace_status;
  logic                       trace_we;
  rv_isa_pkg::reg_idx_t       trace_rd;
  rv_isa_pkg::xlen_t          trace_data;

  // instruction memory, word addressed by pc bits 9:2
  rv_isa_pkg::insn_t imem [0:imem_depth-1];
  // architectural register state in program order
  rv_isa_pkg::xlen_t ref_regs [0:31];
  rv_isa_pkg::insn_t prog [$];

  logic [15:0] lfsr_state;
  int          err_count;
  int          tests_passed;
  int          tests_failed;
  string       cur_test;

  rv_core uut (
    .clk            (clk),
    .rst            (rst),
    .pc_to_imem     (pc_to_imem),
    .insn_from_imem (insn_from_imem),
    .trace_pc       (trace_pc),
    .trace_insn     (trace_insn),
    .trace_status   (trace_status),
    .trace_we       (trace_we),
    .trace_rd       (trace_rd),
    .trace_data     (trace_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // imem answer for the current fetch address
  always @(posedge clk) begin
    #1;
    insn_from_imem = imem[pc_to_imem[9:2]];
  end

  initial begin
    #(watchdog_cycles * 10);
    $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
    $display("*** FAILED ***");
    $finish;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_next_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_next_bit()};
    end
    return val;
  endfunction

  // encoders for the instruction formats in use
  function automatic rv_isa_pkg::insn_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                               input logic [2:0] f3, input int rd,
                                               input logic [6:0] op);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic rv_isa_pkg::insn_t enc_lui(input int rd, input int imm);
    return {imm[19:0], rd[4:0], rv_isa_pkg::opcode_lui};
  endfunction

  function automatic rv_isa_pkg::insn_t enc_addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], rv_isa_pkg::funct3_add, rd[4:0], rv_isa_pkg::opcode_reg_imm};
  endfunction

  function automatic rv_isa_pkg::insn_t enc_add(input int rd, input int rs1, input int rs2);
    return enc_r(7'b000_0000, rs2, rs1, 3'b000, rd, rv_isa_pkg::opcode_reg_reg);
  endfunction

  // RV32I semantics for lui, addi and add, anything else writes nothing
  task automatic predict(input rv_isa_pkg::insn_t insn, output logic we,
                         output rv_isa_pkg::reg_idx_t rd, output rv_isa_pkg::xlen_t data);
    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       legal;
    op = insn[6:0];
    rd = insn[11:7];
    f3 = insn[14:12];
    f7 = insn[31:25];
    legal = 1'b0;
    data = '0;
    if (op == rv_isa_pkg::opcode_lui) begin
      data = {insn[31:12], 12'h000};
      legal = 1'b1;
    end else if (op == rv_isa_pkg::opcode_reg_imm && f3 == 3'b000) begin
      data = ref_regs[insn[19:15]] + {{20{insn[31]}}, insn[31:20]};
      legal = 1'b1;
    end else if (op == rv_isa_pkg::opcode_reg_reg && f3 == 3'b000 && f7 == 7'b000_0000) begin
      data = ref_regs[insn[19:15]] + ref_regs[insn[24:20]];
      legal = 1'b1;
    end
    we = legal && (rd != 5'd0);
    if (we) begin
      ref_regs[rd] = data;
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("MISMATCH %s %s expected %h actual %h", cur_test, what, expected, actual);
      err_count++;
    end
  endtask

  // five clock edges with rst high, the pipeline must sit at pc 0 meanwhile
  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_value("pc_to_imem in reset", 32'd0, pc_to_imem);
    check_value("trace_status in reset", int'(rv_pipe_pkg::cycle_reset), trace_status);
    @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  // load prog, reset, then follow the trace one retirement per cycle
  task automatic run_program(input string name);
    logic                 exp_we;
    rv_isa_pkg::reg_idx_t exp_rd;
    rv_isa_pkg::xlen_t    exp_data;
    int                   start_errors;
    cur_test = name;
    start_errors = err_count;
    for (int a = 0; a < imem_depth; a++) begin
      imem[a] = {~a[15:0], a[15:0]};
    end
    for (int i = 0; i < prog.size(); i++) begin
      imem[i] = prog[i];
    end
    for (int r = 0; r < 32; r++) begin
      ref_regs[r] = '0;
    end
    apply_reset();
    // four reset bubbles drain out of writeback
    for (int c = 0; c < 4; c++) begin
      @(negedge clk);
      check_value("pc_to_imem", 4 * c, pc_to_imem);
      check_value("trace_status", int'(rv_pipe_pkg::cycle_reset), trace_status);
      check_value("trace_pc", 32'd0, trace_pc);
      check_value("trace_insn", 32'd0, trace_insn);
      check_value("trace_we", 32'd0, trace_we);
    end
    for (int i = 0; i < prog.size(); i++) begin
      @(negedge clk);
      predict(prog[i], exp_we, exp_rd, exp_data);
      check_value("pc_to_imem", 4 * (i + 4), pc_to_imem);
      check_value("trace_status", int'(rv_pipe_pkg::cycle_no_stall), trace_status);
      check_value("trace_pc", 4 * i, trace_pc);
      check_value("trace_insn", prog[i], trace_insn);
      check_value("trace_we", exp_we, trace_we);
      // rd and data only matter when a register is written
      if (exp_we) begin
        check_value("trace_rd", exp_rd, trace_rd);
        check_value("trace_data", exp_data, trace_data);
      end
    end
    if (err_count == start_errors) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", name, err_count - start_errors);
      tests_failed++;
    end
  endtask

  task automatic test_reset_fill();
    prog.delete();
    for (int i = 1; i <= len_fill; i++) begin
      prog.push_back(enc_addi(i, 0, 3 * i));
    end
    run_program("reset_fill");
  endtask

  task automatic test_independent();
    prog.delete();
    prog.push_back(enc_lui(1, 'h12345));
    prog.push_back(enc_addi(2, 0, 100));
    prog.push_back(enc_addi(3, 0, -1));
    prog.push_back(enc_lui(4, 'hfffff));
    prog.push_back(enc_addi(5, 0, -2048));
    prog.push_back(enc_addi(6, 0, 2047));
    prog.push_back(enc_lui(7, 'h80000));
    run_program("independent");
  endtask

  // each consumer reads the rd of the one just before it
  task automatic test_back_to_back();
    prog.delete();
    prog.push_back(enc_addi(1, 0, 5));
    prog.push_back(enc_addi(2, 1, 7));
    prog.push_back(enc_add(3, 2, 1));
    prog.push_back(enc_addi(3, 3, -3));
    prog.push_back(enc_add(4, 3, 3));
    prog.push_back(enc_addi(5, 4, 100));
    prog.push_back(enc_add(6, 5, 5));
    run_program("back_to_back");
  endtask

  // fillers on x10 and up keep producer and consumer two or three apart
  task automatic test_distance();
    prog.delete();
    prog.push_back(enc_addi(1, 0, 11));
    prog.push_back(enc_addi(10, 0, 1));
    prog.push_back(enc_add(2, 1, 1));
    prog.push_back(enc_addi(11, 0, 2));
    prog.push_back(enc_addi(12, 0, 3));
    prog.push_back(enc_addi(3, 2, 100));
    prog.push_back(enc_addi(13, 0, 4));
    prog.push_back(enc_add(4, 3, 1));
    prog.push_back(enc_addi(14, 0, 5));
    prog.push_back(enc_addi(15, 0, 6));
    prog.push_back(enc_add(5, 4, 3));
    run_program("distance");
  endtask

  task automatic test_x0_illegal();
    prog.delete();
    prog.push_back(enc_addi(0, 0, 55));
    prog.push_back(enc_add(1, 0, 0));
    prog.push_back(enc_addi(2, 0, 9));
    prog.push_back(enc_lui(0, 'habcde));
    prog.push_back(enc_addi(3, 0, 1));
    // sub x2, x2, x3
    prog.push_back(enc_r(7'b010_0000, 3, 2, 3'b000, 2, rv_isa_pkg::opcode_reg_reg));
    // unknown opcode aimed at x2
    prog.push_back(enc_r(7'b000_0000, 3, 2, 3'b000, 2, 7'b111_1011));
    prog.push_back(enc_add(4, 2, 0));
    prog.push_back(enc_addi(5, 2, 1));
    // xori x5, x5, 1 has funct3 100
    prog.push_back({12'd1, 5'd5, 3'b100, 5'd5, rv_isa_pkg::opcode_reg_imm});
    prog.push_back(enc_add(6, 5, 0));
    run_program("x0_illegal");
  endtask

  // registers limited to x0..x7 so dependences come up often
  task automatic test_random();
    logic [1:0] kind;
    logic [2:0] rd;
    logic [2:0] rs1;
    logic [2:0] rs2;
    prog.delete();
    for (int i = 0; i < len_rand; i++) begin
      kind = rand_bits(2);
      rd = rand_bits(3);
      rs1 = rand_bits(3);
      if (kind == 2'd0) begin
        prog.push_back(enc_lui(rd, rand_bits(20)));
      end else if (kind == 2'd2) begin
        rs2 = rand_bits(3);
        prog.push_back(enc_add(rd, rs1, rs2));
      end else begin
        prog.push_back(enc_addi(rd, rs1, rand_bits(12)));
      end
    end
    run_program("random");
  endtask

  initial begin
    rst = 1'b1;
    insn_from_imem = '0;
    lfsr_state = 16'd34;
    err_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_reset_fill();
    test_independent();
    test_back_to_back();
    test_distance();
    test_x0_illegal();
    test_random();
    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (err_count == 0 && tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_fetch_decode.sv
rv_regfile.sv
rv_execute.sv
rv_retire.sv
rv_core.sv
tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - rv_isa_pkg.sv
  - rv_pipe_pkg.sv
  - rv_fetch_decode.sv
  - rv_regfile.sv
  - rv_execute.sv
  - rv_retire.sv
  - rv_core.sv
  - target: test
    files:
      - tb_rv_core.sv
